// ==== src/fifo_defs.svh ====
`ifndef FIFO_DEFS_SVH
`define FIFO_DEFS_SVH

// ==================================================
// FIFO sizing shared by the package and the RTL
// ==================================================

`define FIFO_DATA_WIDTH 8     // bits per stored word
`define FIFO_DEPTH 16         // number of words, must stay a power of two
`define FIFO_ALMOST_DIFF 4    // margin in words for both almost flags

`endif

// ==== src/fifo_pkg.sv ====
`default_nettype none
`include "fifo_defs.svh"

package fifo_pkg;

    localparam int ADDR_WIDTH = $clog2(`FIFO_DEPTH);    // address bits for the storage array

    typedef logic [`FIFO_DATA_WIDTH-1:0] data_t;        // one payload word
    typedef logic [ADDR_WIDTH-1:0] addr_t;              // index into the storage array
    typedef logic [ADDR_WIDTH:0] ptr_t;                 // the top bit flips on every wrap of the address

endpackage

`default_nettype wire

// ==== src/fifo_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module fifo_mem (
    input  wire logic            i_clk_wr,     // write domain clock
    input  wire logic            i_clk_rd,     // read domain clock
    input  wire logic            i_wr_en,      // accepted write from the write pointer block
    input  wire fifo_pkg::addr_t i_wr_addr,    // slot to store into
    input  wire fifo_pkg::data_t i_wr_data,    // word to store
    input  wire logic            i_rd_en,      // accepted read from the read pointer block
    input  wire fifo_pkg::addr_t i_rd_addr,    // slot to fetch from
    output fifo_pkg::data_t      o_rd_data     // registered read word
);

    localparam int DEPTH = 2 ** fifo_pkg::ADDR_WIDTH;    // same as the configured FIFO depth

    fifo_pkg::data_t mem [DEPTH];    // the storage array

    // ==================================================
    // write port on the write clock
    // ==================================================

    always_ff @(posedge i_clk_wr) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;    // the pointer block already gated this with full
        end
    end

    // ==================================================
    // read port on the read clock
    // ==================================================

    // The read word appears one read cycle after the accepted read and then holds
    // until the next accepted read replaces it.
    always_ff @(posedge i_clk_rd) begin
        if (i_rd_en) begin
            o_rd_data <= mem[i_rd_addr];    // gated by empty in the pointer block
        end
    end

endmodule

`default_nettype wire

// ==== src/fifo_wr_ptr.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "fifo_defs.svh"

module fifo_wr_ptr #(
    parameter int ALMOST_FULL_DIFF = `FIFO_ALMOST_DIFF    // almost full when this many slots or fewer are free
) (
    input  wire logic            i_clk_wr,         // write domain clock
    input  wire logic            i_rst_n,          // synchronous reset, active low
    input  wire logic            i_write_en,       // write request from the outside
    input  wire fifo_pkg::ptr_t  i_rd_ptr,         // read pointer, binary, already synchronized
    output logic                 o_wr_accept,      // write takes place on this edge
    output fifo_pkg::addr_t      o_wr_addr,        // memory slot for the current write
    output fifo_pkg::ptr_t       o_wr_ptr_gray,    // registered gray copy for the crossing
    output logic                 o_full,           // no free slot left
    output logic                 o_almost_full     // free space at or below the margin
);

    localparam fifo_pkg::ptr_t FULL_LEVEL = fifo_pkg::ptr_t'(`FIFO_DEPTH);    // level when full
    localparam fifo_pkg::ptr_t AFULL_LEVEL =
        fifo_pkg::ptr_t'(`FIFO_DEPTH - ALMOST_FULL_DIFF);                      // lowest almost full level

    fifo_pkg::ptr_t wr_ptr;          // binary write pointer, wrap bit included
    fifo_pkg::ptr_t wr_ptr_next;     // pointer after this edge
    fifo_pkg::ptr_t level_next;      // fill level seen after this edge

    // ==================================================
    // next pointer and fill level
    // ==================================================

    assign o_wr_accept = i_write_en & ~o_full;                    // writes while full are dropped
    assign o_wr_addr   = wr_ptr[fifo_pkg::ADDR_WIDTH-1:0];        // wrap bit is not part of the address
    assign wr_ptr_next = wr_ptr + fifo_pkg::ptr_t'(o_wr_accept);  // advances only on an accepted write

    // The read pointer lags behind the real one, so this level can only be too high.
    // That keeps full pessimistic and never lets a write overrun unread data.
    assign level_next = wr_ptr_next - i_rd_ptr;    // modulo subtraction handles the wrap

    // ==================================================
    // registered pointer state and flags
    // ==================================================

    always_ff @(posedge i_clk_wr) begin
        if (!i_rst_n) begin
            wr_ptr        <= '0;    // start at slot zero
            o_wr_ptr_gray <= '0;    // gray code of zero is zero
            o_full        <= 1'b0;
            o_almost_full <= 1'b0;
        end else begin
            wr_ptr        <= wr_ptr_next;
            o_wr_ptr_gray <= wr_ptr_next ^ (wr_ptr_next >> 1);    // one bit changes per step
            o_full        <= (level_next == FULL_LEVEL);          // rises with the filling write
            o_almost_full <= (level_next >= AFULL_LEVEL);
        end
    end

endmodule

`default_nettype wire

// ==== src/fifo_rd_ptr.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "fifo_defs.svh"

module fifo_rd_ptr #(
    parameter int ALMOST_EMPTY_DIFF = `FIFO_ALMOST_DIFF    // almost empty when this many words or fewer remain
) (
    input  wire logic            i_clk_rd,         // read domain clock
    input  wire logic            i_rst_n,          // synchronous reset, active low
    input  wire logic            i_read_en,        // read request from the outside
    input  wire fifo_pkg::ptr_t  i_wr_ptr,         // write pointer, binary, already synchronized
    output logic                 o_rd_accept,      // read takes place on this edge
    output fifo_pkg::addr_t      o_rd_addr,        // memory slot for the current read
    output fifo_pkg::ptr_t       o_rd_ptr_gray,    // registered gray copy for the crossing
    output logic                 o_empty,          // nothing left to read
    output logic                 o_almost_empty    // fill level at or below the margin
);

    localparam fifo_pkg::ptr_t AEMPTY_LEVEL =
        fifo_pkg::ptr_t'(ALMOST_EMPTY_DIFF);      // highest almost empty level

    fifo_pkg::ptr_t rd_ptr;          // binary read pointer, wrap bit included
    fifo_pkg::ptr_t rd_ptr_next;     // pointer after this edge
    fifo_pkg::ptr_t level_next;      // fill level seen after this edge

    // ==================================================
    // next pointer and fill level
    // ==================================================

    assign o_rd_accept = i_read_en & ~o_empty;                    // reads while empty are dropped
    assign o_rd_addr   = rd_ptr[fifo_pkg::ADDR_WIDTH-1:0];        // low bits select the slot
    assign rd_ptr_next = rd_ptr + fifo_pkg::ptr_t'(o_rd_accept);  // advances only on an accepted read

    // The synchronized write pointer is old, so this level can only be too low
    // and empty never reports a word that has not reached the memory.
    assign level_next = i_wr_ptr - rd_ptr_next;    // modulo subtraction handles the wrap

    // ==================================================
    // registered pointer state and flags
    // ==================================================

    always_ff @(posedge i_clk_rd) begin
        if (!i_rst_n) begin
            rd_ptr         <= '0;
            o_rd_ptr_gray  <= '0;
            o_empty        <= 1'b1;    // nothing stored after reset
            o_almost_empty <= 1'b1;
        end else begin
            rd_ptr         <= rd_ptr_next;
            o_rd_ptr_gray  <= rd_ptr_next ^ (rd_ptr_next >> 1);    // binary to gray
            o_empty        <= (level_next == '0);                  // rises with the draining read
            o_almost_empty <= (level_next <= AEMPTY_LEVEL);
        end
    end

endmodule

`default_nettype wire

// ==== src/ptr_sync.sv ====
`timescale 1ns/10ps
`default_nettype none

module ptr_sync (
    input  wire logic           i_clk,         // destination domain clock
    input  wire logic           i_rst_n,       // synchronous reset, active low
    input  wire fifo_pkg::ptr_t i_ptr_gray,    // gray pointer from the source domain
    output fifo_pkg::ptr_t      o_ptr_bin      // binary pointer in the destination domain
);

    localparam int MSB = $bits(fifo_pkg::ptr_t) - 1;    // top bit of the pointer

    fifo_pkg::ptr_t sync_meta;    // first stage, may go metastable
    fifo_pkg::ptr_t sync_gray;    // second stage, settled gray value

    // ==================================================
    // two flop synchronizer
    // ==================================================

    // Only one bit of the gray code moves per increment, so a sample caught mid
    // change resolves to either the old or the new pointer and nothing else.
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            sync_meta <= '0;    // matches the reset pointer on the far side
            sync_gray <= '0;
        end else begin
            sync_meta <= i_ptr_gray;
            sync_gray <= sync_meta;
        end
    end

    // ==================================================
    // gray to binary
    // ==================================================

    always_comb begin
        o_ptr_bin[MSB] = sync_gray[MSB];    // top bit is shared by both codes
        for (int i = MSB - 1; i >= 0; i--) begin
            o_ptr_bin[i] = o_ptr_bin[i+1] ^ sync_gray[i];    // running xor from the top down
        end
    end

endmodule

`default_nettype wire

// ==== src/fifo.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "fifo_defs.svh"

module fifo (
    input  wire logic            i_clk_wr,          // write domain clock
    input  wire logic            i_clk_rd,          // read domain clock
    input  wire logic            i_rst_n,           // synchronous reset, sampled in both domains
    input  wire fifo_pkg::data_t i_data_in,         // word to write
    input  wire logic            i_write_en,        // ignored while full
    input  wire logic            i_read_en,         // ignored while empty
    output wire fifo_pkg::data_t o_data_out,        // read word, one read cycle after the read
    output wire logic            o_empty,
    output wire logic            o_almost_empty,
    output wire logic            o_full,
    output wire logic            o_almost_full
);

    wire logic            wr_accept;        // write happens on this write edge
    wire logic            rd_accept;        // read happens on this read edge
    wire fifo_pkg::addr_t wr_addr;          // write slot
    wire fifo_pkg::addr_t rd_addr;          // read slot
    wire fifo_pkg::ptr_t  wr_ptr_gray;      // write pointer leaving the write domain
    wire fifo_pkg::ptr_t  rd_ptr_gray;      // read pointer leaving the read domain
    wire fifo_pkg::ptr_t  wr_ptr_sync;      // write pointer as seen by the read side
    wire fifo_pkg::ptr_t  rd_ptr_sync;      // read pointer as seen by the write side

    // ==================================================
    // storage
    // ==================================================

    fifo_mem u_mem (
        .i_clk_wr  (i_clk_wr),
        .i_clk_rd  (i_clk_rd),
        .i_wr_en   (wr_accept),     // only accepted writes reach the array
        .i_wr_addr (wr_addr),
        .i_wr_data (i_data_in),
        .i_rd_en   (rd_accept),
        .i_rd_addr (rd_addr),
        .o_rd_data (o_data_out)
    );

    // ==================================================
    // pointer blocks, one per domain
    // ==================================================

    fifo_wr_ptr #(.ALMOST_FULL_DIFF(`FIFO_ALMOST_DIFF)) u_wr_ptr (
        .i_clk_wr      (i_clk_wr),
        .i_rst_n       (i_rst_n),
        .i_write_en    (i_write_en),
        .i_rd_ptr      (rd_ptr_sync),
        .o_wr_accept   (wr_accept),
        .o_wr_addr     (wr_addr),
        .o_wr_ptr_gray (wr_ptr_gray),
        .o_full        (o_full),
        .o_almost_full (o_almost_full)
    );

    fifo_rd_ptr #(.ALMOST_EMPTY_DIFF(`FIFO_ALMOST_DIFF)) u_rd_ptr (
        .i_clk_rd       (i_clk_rd),
        .i_rst_n        (i_rst_n),
        .i_read_en      (i_read_en),
        .i_wr_ptr       (wr_ptr_sync),
        .o_rd_accept    (rd_accept),
        .o_rd_addr      (rd_addr),
        .o_rd_ptr_gray  (rd_ptr_gray),
        .o_empty        (o_empty),
        .o_almost_empty (o_almost_empty)
    );

    // ==================================================
    // clock crossings
    // ==================================================

    ptr_sync u_sync_w2r (
        .i_clk      (i_clk_rd),       // write pointer into the read domain
        .i_rst_n    (i_rst_n),
        .i_ptr_gray (wr_ptr_gray),
        .o_ptr_bin  (wr_ptr_sync)
    );

    ptr_sync u_sync_r2w (
        .i_clk      (i_clk_wr),       // read pointer into the write domain
        .i_rst_n    (i_rst_n),
        .i_ptr_gray (rd_ptr_gray),
        .o_ptr_bin  (rd_ptr_sync)
    );

endmodule

`default_nettype wire

// ==== verif/fifo_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "fifo_defs.svh"

module fifo_tb;

    localparam int DEPTH        = `FIFO_DEPTH;                         // words in the FIFO
    localparam int AFULL_LEVEL  = `FIFO_DEPTH - `FIFO_ALMOST_DIFF;     // almost full from this level
    localparam int AEMPTY_LEVEL = `FIFO_ALMOST_DIFF;                   // almost empty up to this level
    localparam int MAX_CYCLES   = 3000;                                // write cycles before giving up

    logic            i_clk_wr;
    logic            i_clk_rd;
    logic            i_rst_n;
    fifo_pkg::data_t i_data_in;
    logic            i_write_en;
    logic            i_read_en;
    fifo_pkg::data_t o_data_out;
    logic            o_empty;
    logic            o_almost_empty;
    logic            o_full;
    logic            o_almost_full;

    fifo_pkg::data_t model [$];       // words written but not yet read with the oldest first
    fifo_pkg::data_t rd_expect;       // word due on o_data_out after the last accepted read
    logic            rd_pending;      // an accepted read still waits for its compare
    logic [31:0]     wr_lcg;          // generator state for the write side
    logic [31:0]     rd_lcg;          // generator state for the read side
    logic            wr_done;         // writer of the concurrent test has stopped
    int              wr_cycles = 0;   // write clock cycles since time zero

    fifo i_dut (
        .i_clk_wr       (i_clk_wr),
        .i_clk_rd       (i_clk_rd),
        .i_rst_n        (i_rst_n),
        .i_data_in      (i_data_in),
        .i_write_en     (i_write_en),
        .i_read_en      (i_read_en),
        .o_data_out     (o_data_out),
        .o_empty        (o_empty),
        .o_almost_empty (o_almost_empty),
        .o_full         (o_full),
        .o_almost_full  (o_almost_full)
    );

    // ==================================================
    // clocks and run limit
    // ==================================================

    initial begin
        i_clk_wr = 1'b0;
        forever #10 i_clk_wr = ~i_clk_wr;    // 20 ns write period
    end

    initial begin
        i_clk_rd = 1'b0;
        forever #14 i_clk_rd = ~i_clk_rd;    // 28 ns read period
    end

    always @(posedge i_clk_wr) begin
        wr_cycles = wr_cycles + 1;
        if (wr_cycles >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d write cycles", MAX_CYCLES);
            $display("Testbench failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // ==================================================
    // helpers
    // ==================================================

    function automatic logic [31:0] lcg_next(inout logic [31:0] state);
        state = state * 32'd1103515245 + 32'd12345;    // classic 32 bit LCG step
        return state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
            $display("Testbench failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // call right after a falling write edge; the write lands when full is low now
    task automatic write_step(input logic want);
        logic [31:0] rnd;
        rnd        = lcg_next(wr_lcg);
        i_write_en = want;
        i_data_in  = rnd[23:16];    // upper bits of the LCG are the better mixed ones
        if (want && !o_full) begin
            model.push_back(rnd[23:16]);
        end
    endtask

    // call right after a falling read edge; compares the word of the previous read first
    task automatic read_step(input logic want);
        if (rd_pending) begin
            check_value("o_data_out", o_data_out, rd_expect);
            rd_pending = 1'b0;
        end
        i_read_en = want;
        if (want && !o_empty) begin
            if (model.size() == 0) begin
                $display("at %0t ns the FIFO accepted a read with nothing written", $time);
                $display("Testbench failed");
                $fatal(1, "read of a word that does not exist");
            end
            rd_expect  = model.pop_front();
            rd_pending = 1'b1;
        end
    endtask

    task automatic drain_model();
        while (model.size() > 0 || rd_pending) begin
            @(negedge i_clk_rd);
            read_step(model.size() > 0);    // keeps reading until every written word came out
        end
    endtask

    task automatic settle();
        repeat (4) @(negedge i_clk_rd);    // 4 read cycles also span more than 4 write cycles
    endtask

    // ==================================================
    // tests
    // ==================================================

    task automatic test_reset_state();
        check_value("o_empty", o_empty, 1);
        check_value("o_almost_empty", o_almost_empty, 1);
        check_value("o_full", o_full, 0);
        check_value("o_almost_full", o_almost_full, 0);
    endtask

    task automatic test_ordered_transfer();
        repeat (10) begin
            @(negedge i_clk_wr);
            write_step(1'b1);
        end
        @(negedge i_clk_wr);
        write_step(1'b0);
        check_value("accepted writes", model.size(), 10);
        while (o_empty) @(negedge i_clk_rd);    // crossing latency varies, so wait for the flag
        drain_model();
        settle();
        check_value("o_empty", o_empty, 1);
    endtask

    task automatic test_full_drop();
        for (int n = 0; n < 20; n++) begin
            @(negedge i_clk_wr);
            check_value("o_full", o_full, model.size() >= DEPTH);    // full only after 16 writes
            write_step(1'b1);
        end
        @(negedge i_clk_wr);
        write_step(1'b0);
        check_value("o_full", o_full, 1);
        drain_model();
        settle();
        check_value("o_empty", o_empty, 1);
        repeat (4) begin
            @(negedge i_clk_rd);
            read_step(1'b1);    // reads against an empty FIFO
        end
        @(negedge i_clk_rd);
        read_step(1'b0);
        check_value("o_empty", o_empty, 1);
        check_value("o_almost_empty", o_almost_empty, 1);
        check_value("o_data_out", o_data_out, rd_expect);    // still the last real word
    endtask

    task automatic test_almost_thresholds();
        for (int level = 0; level <= DEPTH; level++) begin
            if (level > 0) begin
                @(negedge i_clk_wr);
                write_step(1'b1);
                @(negedge i_clk_wr);
                write_step(1'b0);
            end
            settle();
            check_value("o_almost_full", o_almost_full, level >= AFULL_LEVEL);
            check_value("o_almost_empty", o_almost_empty, level <= AEMPTY_LEVEL);
            check_value("o_full", o_full, level == DEPTH);
            check_value("o_empty", o_empty, level == 0);
        end
        drain_model();
        settle();
    endtask

    task automatic test_concurrent();
        logic [31:0] wr_rnd;
        logic [31:0] rd_rnd;
        wr_done = 1'b0;
        fork
            begin
                for (int n = 0; n < 400; n++) begin
                    @(negedge i_clk_wr);
                    wr_rnd = lcg_next(wr_lcg);
                    // heavy writes first to reach full, light writes later to run empty
                    write_step(n < 200 ? (wr_rnd[30] | wr_rnd[29]) : (wr_rnd[30] & wr_rnd[29]));
                end
                @(negedge i_clk_wr);
                write_step(1'b0);
                wr_done = 1'b1;
            end
            begin
                while (!wr_done || model.size() > 0 || rd_pending) begin
                    @(negedge i_clk_rd);
                    rd_rnd = lcg_next(rd_lcg);
                    read_step(wr_done ? model.size() > 0 : rd_rnd[30]);
                end
            end
        join
        settle();
        check_value("o_empty", o_empty, 1);    // every written word came out once
    endtask

    // ==================================================
    // main sequence
    // ==================================================

    initial begin
        i_rst_n    = 1'b0;
        i_write_en = 1'b0;
        i_read_en  = 1'b0;
        i_data_in  = '0;
        rd_pending = 1'b0;
        rd_expect  = '0;
        wr_done    = 1'b0;
        wr_lcg     = 32'd58411;
        rd_lcg     = 32'd58411;
        repeat (5) @(negedge i_clk_wr);    // reset spans 5 write and 4 read edges
        i_rst_n = 1'b1;
        test_reset_state();
        test_ordered_transfer();
        test_full_drop();
        test_almost_thresholds();
        test_concurrent();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+src
src/fifo_pkg.sv
src/fifo_mem.sv
src/fifo_wr_ptr.sv
src/fifo_rd_ptr.sv
src/ptr_sync.sv
src/fifo.sv
verif/fifo_tb.sv

// ==== Bender.yml ====
package:
  name: dual_clock_fifo

export_include_dirs:
  - src

sources:
  - src/fifo_pkg.sv
  - src/fifo_mem.sv
  - src/fifo_wr_ptr.sv
  - src/fifo_rd_ptr.sv
  - src/ptr_sync.sv
  - src/fifo.sv
  - target: test
    files:
      - verif/fifo_tb.sv
